//--- design/cnn_types_pkg.sv
package cnn_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////////////////////////////////////////

	localparam int PIX_W   = 8;  // Pixels and weights
	localparam int ACC_W   = 20; // Nine-tap sums and biases
	localparam int OUT_W   = 24; // Final result after bias and shift
	localparam int SHIFT_W = 5;

	typedef logic signed [PIX_W-1:0] pixel_t;
	typedef logic signed [PIX_W-1:0] weight_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic signed [ACC_W-1:0] bias_t;
	typedef logic signed [OUT_W-1:0] out_t;

	////////////////////////////////////////////////////////////////////////////
	// Feature side
	////////////////////////////////////////////////////////////////////////////

	// One buffer line, pixel 0 in the low bits
	typedef struct packed {
		pixel_t [3:0] pix;
	} feat_row_t;

	// 4x4 window, row 0 lowest
	typedef struct packed {
		feat_row_t [3:0] row;
	} tile_t;

	////////////////////////////////////////////////////////////////////////////
	// Weight side and results
	////////////////////////////////////////////////////////////////////////////

	// Tap index is row*3 + col
	typedef struct packed {
		weight_t [8:0] tap;
	} kernel_t;

	typedef struct packed {
		kernel_t kernel;
		bias_t   bias;
	} chan_weights_t;

	// Index is out_row*2 + out_col
	typedef struct packed {
		out_t [3:0] val;
	} out_quad_t;

endpackage

//--- design/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

	localparam int FEAT_ADDR_W = 7; // Feature line buffer depth 128
	localparam int KER_ADDR_W  = 5; // 32 kernel sets per channel

	typedef enum logic {
		OP_CONV      = 1'b0,
		OP_CONV_POOL = 1'b1
	} opcode_e;

	// One entry of the instruction FIFO
	typedef struct packed {
		opcode_e                           opcode;
		logic [FEAT_ADDR_W-1:0]            feat_addr; // First of four rows
		logic [KER_ADDR_W-1:0]             ker_addr;
		logic [cnn_types_pkg::SHIFT_W-1:0] shift;
	} conv_inst_t;

	// Buffer write strobes from outside
	typedef struct packed {
		logic                     en;
		logic [FEAT_ADDR_W-1:0]   addr;
		cnn_types_pkg::feat_row_t row;
	} feat_wr_t;

	typedef struct packed {
		logic                         en;
		logic [7:0]                   chan; // Output channel select
		logic [KER_ADDR_W-1:0]        addr;
		cnn_types_pkg::chan_weights_t data;
	} ker_wr_t;

	// What the PE needs from the instruction
	typedef struct packed {
		opcode_e                           opcode;
		logic [cnn_types_pkg::SHIFT_W-1:0] shift;
	} conv_op_t;

endpackage

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cnn_ctrl_pkg::conv_inst_t instruct,
	input  logic                     inst_empty,
	input  logic                     busy,
	output logic                     inst_req,
	output logic                     start,
	output cnn_ctrl_pkg::conv_inst_t cur_inst
);

	typedef enum logic {
		S_IDLE,
		S_ISSUE
	} state_e;

	state_e state;

	// Show-ahead FIFO, head entry is taken in the same cycle as the request
	assign inst_req = (state == S_IDLE) && !inst_empty && !busy;

	// One cycle after the pop
	assign start = (state == S_ISSUE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (inst_req)
						state <= S_ISSUE;
				end
				S_ISSUE: begin
					state <= S_IDLE; // Tile fetch raises busy next cycle
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Instruction stays on cur_inst until the next pop
	always_ff @(posedge clk) begin
		if (inst_req)
			cur_inst <= instruct;
	end

endmodule

//--- design/tile_fetch.sv
`timescale 1ns/1ps

module tile_fetch (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  cnn_ctrl_pkg::conv_inst_t cur_inst,
	input  cnn_ctrl_pkg::feat_wr_t   feat_wr,
	output logic                     busy,
	output cnn_types_pkg::tile_t     tile,
	output logic                     tile_valid
);

	import cnn_types_pkg::*;
	import cnn_ctrl_pkg::*;

	localparam int FEAT_DEPTH = 2 ** FEAT_ADDR_W;

	feat_row_t              line_buf [FEAT_DEPTH];
	feat_row_t              rd_q;
	feat_row_t [2:0]        part_q;  // Rows 0..2 while the tile builds up
	logic [FEAT_ADDR_W-1:0] rd_addr;
	logic [FEAT_ADDR_W-1:0] ptr_q;
	logic [2:0]             phase;   // 1..4 while read data returns

	////////////////////////////////////////////////////////////////////////////
	// Line buffer
	////////////////////////////////////////////////////////////////////////////

	// First row straight from the instruction, the rest from the pointer
	assign rd_addr = start ? cur_inst.feat_addr : ptr_q;

	always_ff @(posedge clk) begin
		if (feat_wr.en)
			line_buf[feat_wr.addr] <= feat_wr.row;
		rd_q  <= line_buf[rd_addr];
		ptr_q <= rd_addr + 1'b1; // Wraps at the buffer depth
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////////////////////

	assign busy = (phase != 3'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase      <= 3'd0;
			tile_valid <= 1'b0;
		end else begin
			tile_valid <= (phase == 3'd4); // Last row lands this cycle
			if (start)
				phase <= 3'd1;
			else if (phase == 3'd4)
				phase <= 3'd0;
			else if (busy)
				phase <= phase + 3'd1;
		end
	end

	// Rows shift in from the top so row 0 ends lowest
	always_ff @(posedge clk) begin
		if (busy)
			part_q <= {rd_q, part_q[2:1]};
		if (phase == 3'd4)
			tile <= {rd_q, part_q}; // Output held until the next tile is done
	end

endmodule

//--- design/kernel_fetch.sv
`timescale 1ns/1ps

module kernel_fetch #(
	parameter int N_CHAN = 2
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      start,
	input  cnn_ctrl_pkg::conv_inst_t                  cur_inst,
	input  cnn_ctrl_pkg::ker_wr_t                     ker_wr,
	output cnn_types_pkg::chan_weights_t [N_CHAN-1:0] weights,
	output cnn_ctrl_pkg::conv_op_t                    op
);

	import cnn_types_pkg::*;
	import cnn_ctrl_pkg::*;

	localparam int KER_DEPTH = 2 ** KER_ADDR_W;

	chan_weights_t bank [N_CHAN][KER_DEPTH]; // One bank per output channel
	chan_weights_t rd_q [N_CHAN];
	conv_op_t      op_pend;
	logic          rd_vld;

	////////////////////////////////////////////////////////////////////////////
	// Kernel and bias banks
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int ch = 0; ch < N_CHAN; ch++) begin
			if (ker_wr.en && ker_wr.chan == 8'(ch))
				bank[ch][ker_wr.addr] <= ker_wr.data;
			if (start)
				rd_q[ch] <= bank[ch][cur_inst.ker_addr]; // All banks in parallel
		end
		if (start) begin
			op_pend.opcode <= cur_inst.opcode;
			op_pend.shift  <= cur_inst.shift;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_vld <= 1'b0;
		else
			rd_vld <= start;
	end

	// Kernel set and op move together, stable from two cycles after start
	always_ff @(posedge clk) begin
		if (rd_vld) begin
			for (int ch = 0; ch < N_CHAN; ch++) begin
				weights[ch] <= rd_q[ch];
			end
			op <= op_pend;
		end
	end

endmodule

//--- design/conv_pe.sv
`timescale 1ns/1ps

module conv_pe #(
	parameter int N_CHAN = 2
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  cnn_types_pkg::tile_t                      tile,
	input  logic                                      tile_valid,
	input  cnn_types_pkg::chan_weights_t [N_CHAN-1:0] weights,
	input  cnn_ctrl_pkg::conv_op_t                    op,
	output cnn_types_pkg::out_quad_t [N_CHAN-1:0]     result,
	output logic                                      result_pooled,
	output logic                                      result_valid
);

	import cnn_types_pkg::*;
	import cnn_ctrl_pkg::*;

	acc_t                   sum_q  [N_CHAN][4]; // Window sums per position
	bias_t                  bias_q [N_CHAN];
	conv_op_t               op_q;
	logic                   s1_vld;
	out_quad_t [N_CHAN-1:0] res_d;

	// 3x3 window at output position (oi, oj) of the 4x4 tile
	function automatic acc_t window_sum(tile_t t, kernel_t k, int oi, int oj);
		acc_t    sum;
		pixel_t  px;
		weight_t wt;
		sum = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				px  = t.row[oi+r].pix[oj+c];
				wt  = k.tap[r*3+c];
				sum = sum + px * wt; // Nine 16-bit products fit in ACC_W
			end
		end
		return sum;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stage one, multiply-accumulate
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (tile_valid) begin
			for (int ch = 0; ch < N_CHAN; ch++) begin
				for (int p = 0; p < 4; p++) begin
					sum_q[ch][p] <= window_sum(tile, weights[ch].kernel, p / 2, p % 2);
				end
				bias_q[ch] <= weights[ch].bias;
			end
			op_q <= op;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage two, bias, shift and pool
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		out_t v [4];
		out_t vmax;
		for (int ch = 0; ch < N_CHAN; ch++) begin
			// Widen first so the bias add cannot overflow
			for (int p = 0; p < 4; p++) begin
				v[p] = (out_t'(sum_q[ch][p]) + out_t'(bias_q[ch])) >>> op_q.shift;
			end
			vmax = v[0];
			for (int p = 1; p < 4; p++) begin
				if (v[p] > vmax)
					vmax = v[p];
			end
			if (op_q.opcode == OP_CONV_POOL) begin
				res_d[ch].val[0]   = vmax;
				res_d[ch].val[3:1] = '0; // Only index 0 carries the pooled value
			end else begin
				for (int p = 0; p < 4; p++) begin
					res_d[ch].val[p] = v[p];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s1_vld) begin
			result        <= res_d;
			result_pooled <= (op_q.opcode == OP_CONV_POOL);
		end
	end

	// Valid follows the data two cycles behind tile_valid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_vld       <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			s1_vld       <= tile_valid;
			result_valid <= s1_vld;
		end
	end

endmodule

//--- design/cnn_tile_top.sv
`timescale 1ns/1ps

module cnn_tile_top #(
	parameter int N_CHAN = 2
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	// Instruction FIFO, show-ahead
	input  cnn_ctrl_pkg::conv_inst_t              instruct,
	input  logic                                  inst_empty,
	output logic                                  inst_req,
	// Buffer loading
	input  cnn_ctrl_pkg::feat_wr_t                feat_wr,
	input  cnn_ctrl_pkg::ker_wr_t                 ker_wr,
	// Results, no back-pressure
	output cnn_types_pkg::out_quad_t [N_CHAN-1:0] result,
	output logic                                  result_pooled,
	output logic                                  result_valid
);

	import cnn_types_pkg::*;
	import cnn_ctrl_pkg::*;

	logic                       start;
	logic                       busy;
	conv_inst_t                 cur_inst;
	tile_t                      tile;
	logic                       tile_valid;
	chan_weights_t [N_CHAN-1:0] weights;
	conv_op_t                   op;

	inst_decoder u_dec (
		.clk        (clk),
		.rst_n      (rst_n),
		.instruct   (instruct),
		.inst_empty (inst_empty),
		.busy       (busy),
		.inst_req   (inst_req),
		.start      (start),
		.cur_inst   (cur_inst)
	);

	////////////////////////////////////////////////////////////////////////////
	// Fetch units run side by side off the same start
	////////////////////////////////////////////////////////////////////////////

	tile_fetch u_tile (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cur_inst   (cur_inst),
		.feat_wr    (feat_wr),
		.busy       (busy),
		.tile       (tile),
		.tile_valid (tile_valid)
	);

	kernel_fetch #(
		.N_CHAN (N_CHAN)
	) u_ker (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.cur_inst (cur_inst),
		.ker_wr   (ker_wr),
		.weights  (weights),
		.op       (op)
	);

	conv_pe #(
		.N_CHAN (N_CHAN)
	) u_pe (
		.clk           (clk),
		.rst_n         (rst_n),
		.tile          (tile),
		.tile_valid    (tile_valid),
		.weights       (weights),
		.op            (op),
		.result        (result),
		.result_pooled (result_pooled),
		.result_valid  (result_valid)
	);

endmodule

//--- bench/tb_cnn_tasks.svh
////////////////////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////////////////////

function automatic logic [15:0] lfsr_next(logic [15:0] s);
	return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000); // Galois taps 16 14 13 11
endfunction

function automatic logic [31:0] rand_bits(int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state); // One step per bit
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

function automatic conv_inst_t make_inst(opcode_e op, int fa, int ka, int sh);
	conv_inst_t inst;
	inst.opcode    = op;
	inst.feat_addr = fa[FEAT_ADDR_W-1:0];
	inst.ker_addr  = ka[KER_ADDR_W-1:0];
	inst.shift     = sh[SHIFT_W-1:0];
	return inst;
endfunction

task automatic load_feat(int addr, feat_row_t row);
	feat_mem[addr % (2**FEAT_ADDR_W)] = row;
	@(posedge clk);
	#1;
	feat_wr.en   = 1'b1;
	feat_wr.addr = addr[FEAT_ADDR_W-1:0];
	feat_wr.row  = row;
	@(posedge clk);
	#1;
	feat_wr.en = 1'b0;
endtask

task automatic load_kernel(int ch, int addr, chan_weights_t w);
	ker_mem[ch][addr] = w;
	@(posedge clk);
	#1;
	ker_wr.en   = 1'b1;
	ker_wr.chan = ch[7:0];
	ker_wr.addr = addr[KER_ADDR_W-1:0];
	ker_wr.data = w;
	@(posedge clk);
	#1;
	ker_wr.en = 1'b0;
endtask

// Random rows from first upward, wrapping at the buffer depth
task automatic load_rand_rows(int first, int n);
	feat_row_t   row;
	for (int i = 0; i < n; i++) begin
		for (int c = 0; c < 4; c++)
			row.pix[c] = pixel_t'(rand_bits(8));
		load_feat((first + i) % (2**FEAT_ADDR_W), row);
	end
endtask

task automatic load_rand_kernels(int addr);
	chan_weights_t w;
	logic [31:0]   r;
	for (int ch = 0; ch < N_CHAN; ch++) begin
		for (int k = 0; k < 9; k++)
			w.kernel.tap[k] = weight_t'(rand_bits(8));
		r      = rand_bits(12);
		w.bias = bias_t'($signed(r[11:0])); // Small bias of either sign
		load_kernel(ch, addr, w);
	end
endtask

task automatic push_inst(conv_inst_t inst);
	quad_set_t exp;
	for (int ch = 0; ch < N_CHAN; ch++)
		exp[ch] = model_quad(inst, ch);
	exp_res_q.push_back(exp);
	exp_pool_q.push_back(inst.opcode == OP_CONV_POOL);
	fifo_q.push_back(inst);
	drive_fifo();
endtask

////////////////////////////////////////////////////////////////////////////
// Waits and checks
////////////////////////////////////////////////////////////////////////////

task automatic wait_result(string name, output quad_set_t res, output logic pooled,
		output int at);
	int   n;
	logic seen;
	n    = 0;
	seen = 1'b0;
	while (!seen && n < 50) begin
		@(negedge clk);
		#1;
		n++;
		seen = (result_valid === 1'b1);
	end
	if (!seen) begin
		abort_run($sformatf("%s: no result_valid within 50 cycles", name));
	end else begin
		res    = result;
		pooled = result_pooled;
		at     = cyc;
	end
endtask

task automatic check_out(string name, out_quad_t exp, out_quad_t act);
	if (act !== exp)
		abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_flag(string name, logic exp, logic act);
	if (act !== exp)
		abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
endtask

task automatic expect_result(string name, output quad_set_t got, output int at);
	quad_set_t exp;
	logic      pooled;
	wait_result(name, got, pooled, at);
	exp = exp_res_q.pop_front();
	for (int ch = 0; ch < N_CHAN; ch++)
		check_out($sformatf("%s ch%0d", name, ch), exp[ch], got[ch]);
	check_flag({name, " pooled"}, exp_pool_q.pop_front(), pooled);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic idle_after_reset();
	for (int i = 0; i < 10; i++) begin
		@(negedge clk);
		#1;
		check_flag("idle inst_req", 1'b0, inst_req);
		check_flag("idle result_valid", 1'b0, result_valid);
	end
endtask

task automatic single_conv();
	feat_row_t     row;
	chan_weights_t w;
	quad_set_t     got;
	int            at;
	for (int r = 0; r < 4; r++) begin
		for (int c = 0; c < 4; c++)
			row.pix[c] = pixel_t'(r * 4 + c - 5); // Ramp through zero
		load_feat(10 + r, row);
	end
	for (int k = 0; k < 9; k++)
		w.kernel.tap[k] = weight_t'(k - 4);
	w.bias = bias_t'(10);
	load_kernel(0, 2, w);
	for (int k = 0; k < 9; k++)
		w.kernel.tap[k] = (k == 4) ? weight_t'(2) : weight_t'(1);
	w.bias = bias_t'(-7);
	load_kernel(1, 2, w);
	req_cyc.delete();
	push_inst(make_inst(OP_CONV, 10, 2, 0));
	expect_result("single_conv", got, at);
	if (req_cyc.size() != 1)
		abort_run("single_conv: expected exactly one inst_req pulse");
	else if (at - req_cyc[0] != 8)
		abort_run($sformatf("FAIL single_conv latency: expected 8, actual %0d",
			at - req_cyc[0]));
endtask

task automatic pool_random();
	quad_set_t got;
	int        at;
	load_rand_rows(40, 4);
	load_rand_kernels(7);
	push_inst(make_inst(OP_CONV_POOL, 40, 7, 3));
	expect_result("pool_random", got, at);
endtask

task automatic queue_four();
	quad_set_t got;
	int        at;
	load_rand_rows(64, 8);
	load_rand_kernels(1);
	load_rand_kernels(3);
	req_cyc.delete();
	push_inst(make_inst(OP_CONV, 64, 1, 2));
	push_inst(make_inst(OP_CONV_POOL, 66, 3, 1));
	push_inst(make_inst(OP_CONV, 68, 3, 0));
	push_inst(make_inst(OP_CONV_POOL, 65, 1, 4));
	for (int i = 0; i < 4; i++)
		expect_result($sformatf("queue_four #%0d", i), got, at);
	if (req_cyc.size() != 4)
		abort_run("queue_four: expected four inst_req pulses");
	for (int i = 1; i < req_cyc.size(); i++) begin
		if (req_cyc[i] - req_cyc[i-1] < 5)
			abort_run($sformatf("FAIL queue_four inst_req gap: expected >= 5, actual %0d",
				req_cyc[i] - req_cyc[i-1]));
	end
endtask

task automatic wrap_rewrite();
	chan_weights_t w;
	quad_set_t     got;
	int            at;
	load_rand_rows(126, 4); // Rows 126, 127, 0, 1
	load_rand_kernels(9);
	push_inst(make_inst(OP_CONV, 126, 9, 0));
	expect_result("wrap", got, at);
	// New bias for channel 1 only
	w      = ker_mem[1][9];
	w.bias = w.bias + bias_t'(1000);
	load_kernel(1, 9, w);
	push_inst(make_inst(OP_CONV, 126, 9, 0));
	expect_result("rewrite", got, at);
endtask

//--- bench/tb_cnn_tile.sv
`timescale 1ns/1ps

module tb_cnn_tile;

	import cnn_types_pkg::*;
	import cnn_ctrl_pkg::*;

	localparam int N_CHAN = 2;

	typedef out_quad_t [N_CHAN-1:0] quad_set_t;

	logic       clk;
	logic       rst_n;
	conv_inst_t instruct;
	logic       inst_empty;
	logic       inst_req;
	feat_wr_t   feat_wr;
	ker_wr_t    ker_wr;
	quad_set_t  result;
	logic       result_pooled;
	logic       result_valid;

	conv_inst_t    fifo_q [$];     // Show-ahead FIFO model
	quad_set_t     exp_res_q [$];
	logic          exp_pool_q [$];
	feat_row_t     feat_mem [2**FEAT_ADDR_W];          // Mirror of the line buffer
	chan_weights_t ker_mem [N_CHAN][2**KER_ADDR_W];
	int            req_cyc [$];    // Cycles with inst_req high
	int            cyc = 0;
	logic [15:0]   lfsr_state;

	cnn_tile_top #(
		.N_CHAN (N_CHAN)
	) u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.instruct      (instruct),
		.inst_empty    (inst_empty),
		.inst_req      (inst_req),
		.feat_wr       (feat_wr),
		.ker_wr        (ker_wr),
		.result        (result),
		.result_pooled (result_pooled),
		.result_valid  (result_valid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// FIFO model and cycle monitor
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_fifo();
		inst_empty = (fifo_q.size() == 0);
		if (inst_empty)
			instruct = '0;
		else
			instruct = fifo_q[0]; // Head entry shown ahead
	endtask

	always @(posedge clk) begin
		if (inst_req === 1'b1 && fifo_q.size() > 0)
			fifo_q.delete(0);
		#1;
		drive_fifo();
	end

	always @(negedge clk) begin
		cyc = cyc + 1;
		if (inst_req === 1'b1)
			req_cyc.push_back(cyc);
	end

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Expected quad for one channel from the convolution rules
	function automatic out_quad_t model_quad(conv_inst_t inst, int ch);
		out_quad_t     q;
		chan_weights_t w;
		pixel_t        px;
		weight_t       wt;
		int            acc;
		int            best;
		int            vals [4];
		w = ker_mem[ch][inst.ker_addr];
		for (int p = 0; p < 4; p++) begin
			acc = w.bias;
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					px  = feat_mem[(inst.feat_addr + p / 2 + r) % (2**FEAT_ADDR_W)].pix[p % 2 + c];
					wt  = w.kernel.tap[r * 3 + c];
					acc = acc + px * wt;
				end
			end
			vals[p] = acc >>> inst.shift;
		end
		best = vals[0];
		for (int p = 1; p < 4; p++) begin
			if (vals[p] > best)
				best = vals[p];
		end
		for (int p = 0; p < 4; p++) begin
			if (inst.opcode == OP_CONV_POOL)
				q.val[p] = (p == 0) ? out_t'(best) : out_t'(0);
			else
				q.val[p] = out_t'(vals[p]);
		end
		return q;
	endfunction

	`include "tb_cnn_tasks.svh"

	initial begin
		rst_n      = 1'b0;
		instruct   = '0;
		inst_empty = 1'b1;
		feat_wr    = '0;
		ker_wr     = '0;
		lfsr_state = 16'd59;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		idle_after_reset();
		single_conv();
		pool_random();
		queue_four();
		wrap_rewrite();
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- files.f
+incdir+bench
design/cnn_types_pkg.sv
design/cnn_ctrl_pkg.sv
design/inst_decoder.sv
design/tile_fetch.sv
design/kernel_fetch.sv
design/conv_pe.sv
design/cnn_tile_top.sv
bench/tb_cnn_tile.sv
